// File: verilog/ex_pkg.sv
package ex_pkg;

  ////////////////////
  // Opcodes
  ////////////////////

  // Bits [5:4] pick the group
  // Bit 3 marks subtract, inverted operand or signed compare
  // Bit 2 marks a right shift inside the shift group
  typedef enum logic [5:0] {
    // Adder and logic group, Zba and unary Zbb fill the free slots
    ALU_ADD    = 6'b00_0000,
    ALU_XOR    = 6'b00_0001,
    ALU_OR     = 6'b00_0010,
    ALU_AND    = 6'b00_0011,
    ALU_CLZ    = 6'b00_0100,
    ALU_SH1ADD = 6'b00_0101,
    ALU_SH2ADD = 6'b00_0110,
    ALU_SH3ADD = 6'b00_0111,
    ALU_SUB    = 6'b00_1000,
    ALU_XNOR   = 6'b00_1001,
    ALU_ORN    = 6'b00_1010,
    ALU_ANDN   = 6'b00_1011,
    ALU_CTZ    = 6'b00_1100,
    ALU_CPOP   = 6'b00_1101,
    ALU_ORC_B  = 6'b00_1110,
    ALU_REV8   = 6'b00_1111,
    // Shifter group
    ALU_SLL    = 6'b01_0000,
    ALU_ROL    = 6'b01_0001,
    ALU_BSET   = 6'b01_0010,
    ALU_BCLR   = 6'b01_0011,
    ALU_SRL    = 6'b01_0100,
    ALU_ROR    = 6'b01_0101,
    ALU_BEXT   = 6'b01_0110,
    ALU_SEXT_B = 6'b01_0111,
    ALU_ZEXT_H = 6'b01_1000,
    ALU_SEXT_H = 6'b01_1001,
    ALU_BINV   = 6'b01_1010,
    ALU_SRA    = 6'b01_1100,
    // Comparator group
    ALU_EQ     = 6'b10_0000,
    ALU_NE     = 6'b10_0001,
    ALU_LTU    = 6'b10_0010,
    ALU_GEU    = 6'b10_0011,
    ALU_MINU   = 6'b10_0100,
    ALU_MAXU   = 6'b10_0101,
    ALU_SLTU   = 6'b10_0110,
    ALU_LT     = 6'b10_1010,
    ALU_GE     = 6'b10_1011,
    ALU_MIN    = 6'b10_1100,
    ALU_MAX    = 6'b10_1101,
    ALU_SLT    = 6'b10_1110,
    // Divider group, bit 0 selects the remainder
    DIV_DIVU   = 6'b11_0000,
    DIV_REMU   = 6'b11_0001,
    DIV_DIV    = 6'b11_1000,
    DIV_REM    = 6'b11_1001
  } alu_opcode_e;

  // Bit manipulation support, B_NONE zeroes every Zba and Zbb result
  typedef enum logic [1:0] {
    B_NONE = 2'd0,
    ZBB    = 2'd1
  } b_ext_e;

  ////////////////////
  // Payloads
  ////////////////////

  typedef struct packed {
    alu_opcode_e op;
    logic [31:0] operand_a;
    logic [31:0] operand_b;
  } ex_req_t;

  typedef struct packed {
    logic [31:0] result;
    logic        cmp;
  } ex_rsp_t;

  // Divider borrowing the ALU counter and shifter
  typedef struct packed {
    logic        clz_en;
    logic [31:0] clz_data_rev;
    logic        shift_en;
    logic [5:0]  shift_amt;
    logic [31:0] operand_b;
  } div_alu_req_t;

  // Count reads 32 on an all zero word
  typedef struct packed {
    logic [5:0]  clz_result;
    logic [31:0] op_b_shifted;
  } div_alu_rsp_t;

  // Divider opcodes share the top group
  function automatic logic is_div_op(alu_opcode_e op);
    return op[5:4] == 2'b11;
  endfunction

endpackage

// File: verilog/ex_ff_one.sv
`timescale 1ns/1ps

module ex_ff_one (
  input  logic [31:0] in_i,
  output logic [4:0]  first_one_o,
  output logic        no_ones_o
);

  localparam int unsigned NUM_LEAVES = 32;
  localparam int unsigned NUM_NODES  = 2 * NUM_LEAVES - 1;

  // Heap ordered tree, node k has children 2k+1 and 2k+2
  // Leaves sit in the last NUM_LEAVES slots, bit 0 leftmost
  logic [4:0] node_idx [NUM_NODES];
  logic       node_vld [NUM_NODES];

  // Each leaf carries its own bit index
  for (genvar i = 0; i < NUM_LEAVES; i++) begin : g_leaf
    assign node_idx[NUM_LEAVES-1+i] = 5'(i);
    assign node_vld[NUM_LEAVES-1+i] = in_i[i];
  end

  // Pairwise select, the lower half wins when it holds a one
  for (genvar k = 0; k < NUM_LEAVES - 1; k++) begin : g_node
    assign node_vld[k] = node_vld[2*k+1] | node_vld[2*k+2];
    assign node_idx[k] = node_vld[2*k+1] ? node_idx[2*k+1] : node_idx[2*k+2];
  end

  // Root holds the lowest set bit
  assign first_one_o = node_idx[0];
  assign no_ones_o   = ~node_vld[0];

endmodule

// File: verilog/ex_alu.sv
`timescale 1ns/1ps

module ex_alu #(
  parameter ex_pkg::b_ext_e B_EXT = ex_pkg::B_NONE
) (
  input  ex_pkg::alu_opcode_e  operator_i,
  input  logic [31:0]          operand_a_i,
  input  logic [31:0]          operand_b_i,
  input  ex_pkg::div_alu_req_t div_req_i,
  output logic [31:0]          result_o,
  output logic                 cmp_result_o,
  output ex_pkg::div_alu_rsp_t div_rsp_o
);
  import ex_pkg::*;

  localparam logic B_EN = (B_EXT != B_NONE);

  logic [31:0] operand_a_rev;

  assign operand_a_rev = {<<{operand_a_i}};

  ////////////////////
  // Adder
  ////////////////////

  logic [32:0] adder_in_a;
  logic [32:0] adder_in_b;
  logic [32:0] adder_sum;
  logic [31:0] adder_result;
  logic        adder_sub;

  assign adder_sub = operator_i[3];
  // Carry in rides on an extra low bit, so subtract is a plain add
  assign adder_in_a   = {operand_a_i, 1'b1};
  assign adder_in_b   = {adder_sub ? ~operand_b_i : operand_b_i, adder_sub};
  assign adder_sum    = adder_in_a + adder_in_b;
  assign adder_result = adder_sum[32:1];

  ////////////////////
  // Shifter
  ////////////////////

  logic [5:0]  shift_amt;
  logic [31:0] shift_lo;
  logic [31:0] shift_hi;
  logic [63:0] shift_in;
  logic [63:0] shift_tmp;
  logic [31:0] shift_result;

  // Right shift turns into a left rotate by the negated amount
  always_comb begin
    if (div_req_i.shift_en) begin
      shift_amt = div_req_i.shift_amt;
    end else if (operator_i[2]) begin
      shift_amt = 6'd0 - {1'b0, operand_b_i[4:0]};
    end else begin
      shift_amt = {1'b0, operand_b_i[4:0]};
    end
  end

  // Upper word supplies the fill bits
  always_comb begin
    shift_lo = div_req_i.shift_en ? div_req_i.operand_b : operand_a_i;
    shift_hi = 32'h0;
    case (operator_i)
      ALU_SRA: shift_hi = {32{operand_a_i[31]}};
      ALU_ROL,
      ALU_ROR: shift_hi = operand_a_i;
      // Single bit ops move a one into place
      ALU_BSET,
      ALU_BCLR,
      ALU_BINV: shift_lo = 32'h1;
      default: ;
    endcase
  end

  // 64 bit rotate left
  assign shift_in  = {shift_hi, shift_lo};
  assign shift_tmp = (shift_in << shift_amt) | (shift_in >> (7'd64 - {1'b0, shift_amt}));

  always_comb begin
    case (operator_i)
      ALU_BEXT: shift_result = {31'h0, shift_tmp[0]};
      ALU_BSET: shift_result = operand_a_i | shift_tmp[31:0];
      ALU_BCLR: shift_result = operand_a_i & ~shift_tmp[31:0];
      ALU_BINV: shift_result = operand_a_i ^ shift_tmp[31:0];
      default:  shift_result = shift_tmp[31:0];
    endcase
  end

  // Normalized divisor back to the divider
  assign div_rsp_o.op_b_shifted = shift_tmp[31:0];

  // shNadd, shift amount is the low opcode pair
  logic [31:0] shnadd_result;

  assign shnadd_result = (operand_a_i << operator_i[1:0]) + operand_b_i;

  ////////////////////
  // Comparator
  ////////////////////

  logic is_signed;
  logic is_equal;
  logic is_greater;
  logic is_less;

  assign is_signed  = operator_i[3];
  assign is_equal   = (operand_a_i == operand_b_i);
  // Sign extend by one bit so a single compare covers both forms
  assign is_greater = $signed({is_signed & operand_a_i[31], operand_a_i}) >
                      $signed({is_signed & operand_b_i[31], operand_b_i});
  assign is_less    = ~(is_greater | is_equal);

  // Branch condition, low for anything else
  always_comb begin
    case (operator_i)
      ALU_EQ:          cmp_result_o = is_equal;
      ALU_NE:          cmp_result_o = ~is_equal;
      ALU_LT, ALU_LTU: cmp_result_o = is_less;
      ALU_GE, ALU_GEU: cmp_result_o = ~is_less;
      default:         cmp_result_o = 1'b0;
    endcase
  end

  ////////////////////
  // Bit counts
  ////////////////////

  logic [31:0] ff_in;
  logic [4:0]  ff_first;
  logic        ff_none;
  logic [5:0]  cpop_result;

  // Divider has priority, clz looks at the reversed operand
  always_comb begin
    if (div_req_i.clz_en) begin
      ff_in = div_req_i.clz_data_rev;
    end else if (operator_i == ALU_CTZ) begin
      ff_in = operand_a_i;
    end else begin
      ff_in = operand_a_rev;
    end
  end

  ex_ff_one u_ff_one (
    .in_i        (ff_in),
    .first_one_o (ff_first),
    .no_ones_o   (ff_none)
  );

  assign div_rsp_o.clz_result = ff_none ? 6'd32 : {1'b0, ff_first};

  always_comb begin
    cpop_result = 6'd0;
    for (int i = 0; i < 32; i++) begin
      cpop_result = cpop_result + 6'(operand_a_i[i]);
    end
  end

  ////////////////////
  // Result mux
  ////////////////////

  logic [31:0] b_result;

  // Zba, Zbb and single bit results
  always_comb begin
    case (operator_i)
      ALU_ANDN:   b_result = operand_a_i & ~operand_b_i;
      ALU_ORN:    b_result = operand_a_i | ~operand_b_i;
      ALU_XNOR:   b_result = operand_a_i ^ ~operand_b_i;
      ALU_SH1ADD,
      ALU_SH2ADD,
      ALU_SH3ADD: b_result = shnadd_result;
      ALU_CLZ,
      ALU_CTZ:    b_result = {26'h0, div_rsp_o.clz_result};
      ALU_CPOP:   b_result = {26'h0, cpop_result};
      ALU_MIN,
      ALU_MINU:   b_result = is_greater ? operand_b_i : operand_a_i;
      ALU_MAX,
      ALU_MAXU:   b_result = is_greater ? operand_a_i : operand_b_i;
      ALU_ROL, ALU_ROR, ALU_BSET, ALU_BCLR, ALU_BINV,
      ALU_BEXT:   b_result = shift_result;
      ALU_ORC_B:  b_result = {{8{|operand_a_i[31:24]}}, {8{|operand_a_i[23:16]}},
                              {8{|operand_a_i[15:8]}},  {8{|operand_a_i[7:0]}}};
      ALU_REV8:   b_result = {operand_a_i[7:0], operand_a_i[15:8],
                              operand_a_i[23:16], operand_a_i[31:24]};
      ALU_SEXT_B: b_result = {{24{operand_a_i[7]}}, operand_a_i[7:0]};
      ALU_SEXT_H: b_result = {{16{operand_a_i[15]}}, operand_a_i[15:0]};
      ALU_ZEXT_H: b_result = {16'h0, operand_a_i[15:0]};
      default:    b_result = 32'h0;
    endcase
  end

  always_comb begin
    case (operator_i)
      ALU_ADD, ALU_SUB:          result_o = adder_result;
      ALU_AND:                   result_o = operand_a_i & operand_b_i;
      ALU_OR:                    result_o = operand_a_i | operand_b_i;
      ALU_XOR:                   result_o = operand_a_i ^ operand_b_i;
      ALU_SLL, ALU_SRL, ALU_SRA: result_o = shift_result;
      ALU_SLT, ALU_SLTU:         result_o = {31'h0, is_less};
      // Branches and divides land here as zero
      default:                   result_o = B_EN ? b_result : 32'h0;
    endcase
  end

endmodule

// File: verilog/ex_div.sv
`timescale 1ns/1ps

module ex_div (
  input  logic                 clk,
  input  logic                 rst_n_i,
  input  logic                 start_i,
  input  ex_pkg::alu_opcode_e  op_i,
  input  logic [31:0]          dividend_i,
  input  logic [31:0]          divisor_i,
  output ex_pkg::div_alu_req_t alu_req_o,
  input  ex_pkg::div_alu_rsp_t alu_rsp_i,
  output logic                 busy_o,
  output logic                 done_o,
  output logic [31:0]          result_o
);
  import ex_pkg::*;

  typedef enum logic [1:0] {
    DIV_IDLE,
    DIV_NORM,
    DIV_ITER,
    DIV_FINISH
  } div_state_e;

  div_state_e  state_q;
  logic [5:0]  cnt_q;

  logic        op_signed;
  logic        neg_a;
  logic        neg_b;
  logic [31:0] abs_a;
  logic [31:0] abs_b;
  logic [31:0] clz_src;

  // Payload, loaded on start
  logic [31:0] rem_q;
  logic [31:0] quo_q;
  logic [31:0] dsh_q;
  logic [31:0] abs_b_q;
  logic [5:0]  clz_a_q;
  logic        sign_a_q;
  logic        sign_b_q;
  logic        rem_op_q;
  logic        div_zero_q;

  logic [6:0]  shift_diff;
  logic [32:0] trial;
  logic        trial_fits;
  logic [31:0] res_mag;
  logic        res_neg;

  // Signed operands are worked on as magnitudes
  assign op_signed = op_i[3];
  assign neg_a     = op_signed & dividend_i[31];
  assign neg_b     = op_signed & divisor_i[31];
  assign abs_a     = neg_a ? 32'h0 - dividend_i : dividend_i;
  assign abs_b     = neg_b ? 32'h0 - divisor_i : divisor_i;

  ////////////////////
  // ALU requests
  ////////////////////

  // Dividend is counted in the start cycle, divisor in normalize
  assign clz_src = (state_q == DIV_NORM) ? abs_b_q : abs_a;

  assign alu_req_o.clz_en       = ((state_q == DIV_IDLE) && start_i) || (state_q == DIV_NORM);
  assign alu_req_o.clz_data_rev = {<<{clz_src}};
  assign alu_req_o.shift_en     = (state_q == DIV_NORM);
  assign alu_req_o.shift_amt    = shift_diff[5:0];
  assign alu_req_o.operand_b    = abs_b_q;

  // Negative when the divisor is wider than the dividend
  assign shift_diff = {1'b0, alu_rsp_i.clz_result} - {1'b0, clz_a_q};

  // Restoring step
  assign trial      = {1'b0, rem_q} - {1'b0, dsh_q};
  assign trial_fits = ~trial[32];

  ////////////////////
  // FSM
  ////////////////////

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      state_q <= DIV_IDLE;
      cnt_q   <= 6'd0;
    end else begin
      case (state_q)
        DIV_IDLE: begin
          if (start_i) begin
            state_q <= DIV_NORM;
          end
        end
        DIV_NORM: begin
          // Zero divisor counts 32, smaller dividend skips iterating
          if (alu_rsp_i.clz_result[5] || shift_diff[6]) begin
            state_q <= DIV_FINISH;
          end else begin
            state_q <= DIV_ITER;
            cnt_q   <= shift_diff[5:0];
          end
        end
        DIV_ITER: begin
          if (cnt_q == 6'd0) begin
            state_q <= DIV_FINISH;
          end else begin
            cnt_q <= cnt_q - 6'd1;
          end
        end
        default: state_q <= DIV_IDLE;
      endcase
    end
  end

  // Datapath
  always_ff @(posedge clk) begin
    case (state_q)
      DIV_IDLE: begin
        if (start_i) begin
          rem_q      <= abs_a;
          abs_b_q    <= abs_b;
          sign_a_q   <= neg_a;
          sign_b_q   <= neg_b;
          rem_op_q   <= op_i[0];
          clz_a_q    <= alu_rsp_i.clz_result;
          div_zero_q <= 1'b0;
        end
      end
      DIV_NORM: begin
        // Divisor MSB now lines up with the dividend MSB
        dsh_q <= alu_rsp_i.op_b_shifted;
        quo_q <= 32'h0;
        if (alu_rsp_i.clz_result[5]) begin
          quo_q      <= 32'hffff_ffff;
          div_zero_q <= 1'b1;
        end
      end
      DIV_ITER: begin
        quo_q <= {quo_q[30:0], trial_fits};
        dsh_q <= {1'b0, dsh_q[31:1]};
        if (trial_fits) begin
          rem_q <= trial[31:0];
        end
      end
      default: ;
    endcase
  end

  ////////////////////
  // Sign fix
  ////////////////////

  // Remainder follows the dividend, quotient of a zero divisor stays all ones
  assign res_mag  = rem_op_q ? rem_q : quo_q;
  assign res_neg  = rem_op_q ? sign_a_q : (sign_a_q ^ sign_b_q) & ~div_zero_q;
  assign result_o = res_neg ? 32'h0 - res_mag : res_mag;

  // Busy drops as done rises
  assign busy_o = (state_q == DIV_NORM) || (state_q == DIV_ITER);
  assign done_o = (state_q == DIV_FINISH);

endmodule

// File: verilog/ex_stage.sv
`timescale 1ns/1ps

module ex_stage #(
  parameter ex_pkg::b_ext_e B_EXT = ex_pkg::ZBB
) (
  input  logic            clk,
  input  logic            rst_n_i,
  input  logic            issue_i,
  input  ex_pkg::ex_req_t req_i,
  output logic            busy_o,
  output logic            rsp_valid_o,
  output ex_pkg::ex_rsp_t rsp_o
);
  import ex_pkg::*;

  ex_req_t      req_q;
  logic         valid_q;
  logic         accept;
  logic         req_is_div;
  logic         div_start;
  logic         div_busy;
  logic         div_done;
  logic [31:0]  div_result;
  logic [31:0]  alu_result;
  logic         alu_cmp;
  div_alu_req_t div_alu_req;
  div_alu_rsp_t div_alu_rsp;

  // Issue while busy is dropped, request register stays put
  assign accept = issue_i & ~busy_o;

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= accept;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      req_q <= req_i;
    end
  end

  // Start cycle already counts as busy
  assign req_is_div = is_div_op(req_q.op);
  assign div_start  = valid_q & req_is_div;
  assign busy_o     = div_start | div_busy;

  ex_alu #(
    .B_EXT (B_EXT)
  ) u_alu (
    .operator_i   (req_q.op),
    .operand_a_i  (req_q.operand_a),
    .operand_b_i  (req_q.operand_b),
    .div_req_i    (div_alu_req),
    .result_o     (alu_result),
    .cmp_result_o (alu_cmp),
    .div_rsp_o    (div_alu_rsp)
  );

  ex_div u_div (
    .clk        (clk),
    .rst_n_i    (rst_n_i),
    .start_i    (div_start),
    .op_i       (req_q.op),
    .dividend_i (req_q.operand_a),
    .divisor_i  (req_q.operand_b),
    .alu_req_o  (div_alu_req),
    .alu_rsp_i  (div_alu_rsp),
    .busy_o     (div_busy),
    .done_o     (div_done),
    .result_o   (div_result)
  );

  // ALU answers the cycle after issue, divider on done
  assign rsp_valid_o  = (valid_q & ~req_is_div) | div_done;
  assign rsp_o.result = div_done ? div_result : alu_result;
  // Divider ops leave the branch compare low
  assign rsp_o.cmp    = alu_cmp;

endmodule

// File: test/tb_clk_gen.sv
`timescale 1ns/1ps

module tb_clk_gen #(
  parameter realtime PERIOD     = 8ns,
  parameter int      RST_CYCLES = 3
) (
  output logic clk_o,
  output logic rst_n_o
);

  initial begin
    clk_o = 1'b0;
    forever #(PERIOD / 2) clk_o = ~clk_o;
  end

  // Reset is held low for a fixed number of rising edges
  initial begin
    rst_n_o = 1'b0;
    repeat (RST_CYCLES) @(posedge clk_o);
    #1 rst_n_o = 1'b1;
  end

endmodule

// File: test/ex_props.sv
`timescale 1ns/1ps

module ex_props (
  input logic            clk,
  input logic            rst_n_i,
  input logic            issue_i,
  input ex_pkg::ex_req_t req_i,
  input logic            busy_i,
  input logic            rsp_valid_i
);
  import ex_pkg::*;

  // Accepted ALU issue answers on the next edge
  a_alu_latency: assert property (@(posedge clk) disable iff (!rst_n_i)
    issue_i && !busy_i && !is_div_op(req_i.op) |=> rsp_valid_i)
    else $error("ALU response missing one cycle after issue");

  // No response while a division is in flight, its one answer comes as busy falls
  a_div_single: assert property (@(posedge clk) disable iff (!rst_n_i)
    busy_i |-> !rsp_valid_i)
    else $error("Response while a division is in flight");

  // Quiet outputs after a reset edge
  a_reset_quiet: assert property (@(posedge clk)
    !rst_n_i |=> !busy_i && !rsp_valid_i)
    else $error("Busy or response high after reset");

endmodule

bind ex_stage ex_props u_props (
  .clk         (clk),
  .rst_n_i     (rst_n_i),
  .issue_i     (issue_i),
  .req_i       (req_i),
  .busy_i      (busy_o),
  .rsp_valid_i (rsp_valid_o)
);

// File: test/ex_tb.sv
`timescale 1ns/1ps

module ex_tb;
  import ex_pkg::*;

  localparam int MAX_WAIT = 200;

  logic    clk;
  logic    rst_n;
  logic    issue_i;
  ex_req_t req_i;
  logic    busy_o;
  logic    rsp_valid_o;
  ex_rsp_t rsp_o;

  int      seed = 32'h0e9b_c0b0;
  int      mismatches = 0;
  int      proto_errs = 0;
  int      timeouts = 0;
  ex_req_t exp_q[$];
  ex_req_t cur_req;
  ex_rsp_t exp_rsp;

  alu_opcode_e rv_ops[10] = '{ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR,
                              ALU_SLL, ALU_SRL, ALU_SRA, ALU_SLT, ALU_SLTU};
  alu_opcode_e b_ops[20]  = '{ALU_SH1ADD, ALU_SH2ADD, ALU_SH3ADD, ALU_ANDN, ALU_ORN,
                              ALU_XNOR, ALU_CLZ, ALU_CTZ, ALU_CPOP, ALU_MIN, ALU_MAX,
                              ALU_MINU, ALU_MAXU, ALU_ROL, ALU_ROR, ALU_ORC_B,
                              ALU_REV8, ALU_SEXT_B, ALU_SEXT_H, ALU_ZEXT_H};
  alu_opcode_e br_ops[6]  = '{ALU_EQ, ALU_NE, ALU_LT, ALU_GE, ALU_LTU, ALU_GEU};
  alu_opcode_e dv_ops[4]  = '{DIV_DIV, DIV_DIVU, DIV_REM, DIV_REMU};

  tb_clk_gen u_clk (
    .clk_o   (clk),
    .rst_n_o (rst_n)
  );

  ex_stage #(
    .B_EXT (ZBB)
  ) DUT (
    .clk         (clk),
    .rst_n_i     (rst_n),
    .issue_i     (issue_i),
    .req_i       (req_i),
    .busy_o      (busy_o),
    .rsp_valid_o (rsp_valid_o),
    .rsp_o       (rsp_o)
  );

  ////////////////////
  // Reference
  ////////////////////

  // Expected response straight from the ISA text
  function automatic ex_rsp_t ref_model(ex_req_t r);
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] res;
    logic [4:0]  sh;
    logic        cmp;
    int          n;
    ex_rsp_t     rsp;
    a   = r.operand_a;
    b   = r.operand_b;
    sh  = b[4:0];
    res = 32'h0;
    cmp = 1'b0;
    n   = 0;
    case (r.op)
      ALU_ADD:    res = a + b;
      ALU_SUB:    res = a - b;
      ALU_AND:    res = a & b;
      ALU_OR:     res = a | b;
      ALU_XOR:    res = a ^ b;
      ALU_SLL:    res = a << sh;
      ALU_SRL:    res = a >> sh;
      ALU_SRA:    res = $signed(a) >>> sh;
      ALU_SLT:    res = {31'h0, $signed(a) < $signed(b)};
      ALU_SLTU:   res = {31'h0, a < b};
      ALU_SH1ADD: res = (a << 1) + b;
      ALU_SH2ADD: res = (a << 2) + b;
      ALU_SH3ADD: res = (a << 3) + b;
      ALU_ANDN:   res = a & ~b;
      ALU_ORN:    res = a | ~b;
      ALU_XNOR:   res = ~(a ^ b);
      ALU_CLZ: begin
        for (int i = 31; i >= 0; i--) begin
          if (a[i]) break;
          n++;
        end
        res = 32'(n);
      end
      ALU_CTZ: begin
        for (int i = 0; i < 32; i++) begin
          if (a[i]) break;
          n++;
        end
        res = 32'(n);
      end
      ALU_CPOP: begin
        for (int i = 0; i < 32; i++) n += int'(a[i]);
        res = 32'(n);
      end
      ALU_MIN:    res = ($signed(a) < $signed(b)) ? a : b;
      ALU_MAX:    res = ($signed(a) < $signed(b)) ? b : a;
      ALU_MINU:   res = (a < b) ? a : b;
      ALU_MAXU:   res = (a < b) ? b : a;
      // Shift by 32 yields zero, so no special case for sh of zero
      ALU_ROL:    res = (a << sh) | (a >> (6'd32 - {1'b0, sh}));
      ALU_ROR:    res = (a >> sh) | (a << (6'd32 - {1'b0, sh}));
      ALU_ORC_B: begin
        for (int i = 0; i < 4; i++) res[8*i +: 8] = {8{|a[8*i +: 8]}};
      end
      // Byte i of the result is byte 3-i of the source
      ALU_REV8: begin
        for (int i = 0; i < 4; i++) res[8*i +: 8] = a[8*(3-i) +: 8];
      end
      ALU_SEXT_B: res = 32'($signed(a[7:0]));
      ALU_SEXT_H: res = 32'($signed(a[15:0]));
      ALU_ZEXT_H: res = 32'(a[15:0]);
      ALU_EQ:     cmp = (a == b);
      ALU_NE:     cmp = (a != b);
      ALU_LT:     cmp = ($signed(a) < $signed(b));
      ALU_GE:     cmp = ($signed(a) >= $signed(b));
      ALU_LTU:    cmp = (a < b);
      ALU_GEU:    cmp = (a >= b);
      DIV_DIVU:   res = (b == 0) ? 32'hffff_ffff : a / b;
      DIV_REMU:   res = (b == 0) ? a : a % b;
      DIV_DIV: begin
        if (b == 0) res = 32'hffff_ffff;
        else if (a == 32'h8000_0000 && b == 32'hffff_ffff) res = a;
        else res = $signed(a) / $signed(b);
      end
      DIV_REM: begin
        if (b == 0) res = a;
        else if (a == 32'h8000_0000 && b == 32'hffff_ffff) res = 32'h0;
        else res = $signed(a) % $signed(b);
      end
      default:    res = 32'h0;
    endcase
    rsp.result = res;
    rsp.cmp    = cmp;
    return rsp;
  endfunction

  ////////////////////
  // Checking
  ////////////////////

  task automatic check_value(input string what, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      mismatches++;
      $display("** Error at %0t: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  // Outputs settle mid cycle, so responses are read on the falling edge
  always @(negedge clk) begin
    if (rst_n && rsp_valid_o) begin
      if (exp_q.size() == 0) begin
        proto_errs++;
        $display("Response at %0t arrived with no request outstanding", $time);
      end else begin
        cur_req = exp_q.pop_front();
        exp_rsp = ref_model(cur_req);
        check_value($sformatf("%s %h,%h result", cur_req.op.name(), cur_req.operand_a,
                    cur_req.operand_b), rsp_o.result, exp_rsp.result);
        check_value($sformatf("%s %h,%h cmp", cur_req.op.name(), cur_req.operand_a,
                    cur_req.operand_b), {31'h0, rsp_o.cmp}, {31'h0, exp_rsp.cmp});
        // Busy is already low in the cycle that carries a response
        check_value("busy with response", {31'h0, busy_o}, 32'h0);
      end
    end
  end

  ////////////////////
  // Stimulus
  ////////////////////

  // Zero, all ones, one set bit or fully random
  function automatic logic [31:0] pick_operand();
    logic [31:0] sel;
    sel = $random(seed);
    case (sel[1:0])
      2'd0:    return 32'h0;
      2'd1:    return 32'hffff_ffff;
      2'd2:    return 32'h1 << sel[6:2];
      default: return $random(seed);
    endcase
  endfunction

  // Drives one request for a single cycle, expect marks an accepted issue
  task automatic issue_op(input alu_opcode_e op, input logic [31:0] a,
                          input logic [31:0] b, input logic expect_rsp);
    issue_i         = 1'b1;
    req_i.op        = op;
    req_i.operand_a = a;
    req_i.operand_b = b;
    if (expect_rsp) exp_q.push_back(req_i);
    @(posedge clk);
    #1 issue_i = 1'b0;
  endtask

  task automatic wait_not_busy();
    int cyc;
    cyc = 0;
    while (busy_o && cyc < MAX_WAIT) begin
      @(posedge clk);
      #1 cyc++;
    end
    if (busy_o) begin
      timeouts++;
      $display("Timeout at %0t while waiting for the divider to finish", $time);
    end
  endtask

  task automatic run_div(input alu_opcode_e op, input logic [31:0] a, input logic [31:0] b);
    issue_op(op, a, b, 1'b1);
    wait_not_busy();
  endtask

  task automatic drain_responses();
    int cyc;
    cyc = 0;
    while (exp_q.size() != 0 && cyc < MAX_WAIT) begin
      @(posedge clk);
      #1 cyc++;
    end
    if (exp_q.size() != 0) begin
      timeouts++;
      $display("Timeout at %0t with %0d responses still missing", $time, exp_q.size());
    end
    repeat (4) @(posedge clk);
    #1;
  endtask

  initial begin
    int          cyc;
    logic [31:0] dv_b;
    issue_i = 1'b0;
    req_i   = '0;
    cyc     = 0;
    while (!rst_n && cyc < MAX_WAIT) begin
      @(posedge clk);
      #1 cyc++;
    end
    if (!rst_n) begin
      timeouts++;
      $display("Reset never released");
    end

    // Quiet period, any response here is flagged by the compare process
    repeat (5) @(posedge clk);
    #1;

    // Back-to-back base ISA
    for (int i = 0; i < 60; i++) begin
      issue_op(rv_ops[$unsigned($random(seed)) % 10], $random(seed), $random(seed), 1'b1);
    end
    // Bit manipulation on edge operands
    for (int i = 0; i < 120; i++) begin
      issue_op(b_ops[$unsigned($random(seed)) % 20], pick_operand(), pick_operand(), 1'b1);
    end
    // Branch conditions, equal operands now and then
    for (int i = 0; i < 60; i++) begin
      dv_b = pick_operand();
      issue_op(br_ops[$unsigned($random(seed)) % 6], (i % 4 == 0) ? dv_b : pick_operand(),
               dv_b, 1'b1);
    end
    drain_responses();

    // Random divisions with a spread of divisor widths
    for (int i = 0; i < 40; i++) begin
      dv_b = $random(seed);
      dv_b = dv_b >> ($unsigned($random(seed)) % 32);
      run_div(dv_ops[$unsigned($random(seed)) % 4], $random(seed), dv_b);
    end

    // Corner cases
    for (int i = 0; i < 4; i++) begin
      run_div(dv_ops[i], $random(seed), 32'h0);
      run_div(dv_ops[i], 32'h8000_0000, 32'hffff_ffff);
      run_div(dv_ops[i], 32'h0000_0005, 32'h0000_0731);
      run_div(dv_ops[i], 32'hffff_fffb, 32'h0000_0007);
    end

    // Issue during a division must be dropped
    issue_op(DIV_DIVU, 32'hdead_beef, 32'h0000_0003, 1'b1);
    issue_op(ALU_ADD, 32'h1, 32'h2, 1'b0);
    wait_not_busy();
    drain_responses();

    $display("Error counts: %0d mismatches, %0d protocol, %0d timeouts",
             mismatches, proto_errs, timeouts);
    if (mismatches + proto_errs + timeouts == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

// File: build.f
verilog/ex_pkg.sv
verilog/ex_ff_one.sv
verilog/ex_alu.sv
verilog/ex_div.sv
verilog/ex_stage.sv
test/tb_clk_gen.sv
test/ex_props.sv
test/ex_tb.sv

// File: Makefile
LOG = sim.log

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -j 0 -f build.f --top-module ex_tb -o ex_tb_sim

run: build
	./obj_dir/ex_tb_sim | tee $(LOG)
	grep -q "TESTS PASSED" $(LOG)

lint:
	verilator --lint-only -Wall --timing -f build.f --top-module ex_tb
	verilator --lint-only -Wall verilog/ex_pkg.sv verilog/ex_ff_one.sv verilog/ex_alu.sv \
		verilog/ex_div.sv verilog/ex_stage.sv --top-module ex_stage

clean:
	rm -rf obj_dir $(LOG)
